// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_uart_top
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
FAIL_MSG  := FAIL: see errors above

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run $(TOP), check $(LOG) for failure"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@status=0; ./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== hw/baud_tick_gen.sv ====
`default_nettype none

module baud_tick_gen #(
	parameter int CLKS_PER_TICK = 4  // system clocks per oversampling tick
) (
	input  logic clk,
	input  logic reset,
	output logic o_tick
);

	localparam int CNT_W = $clog2(CLKS_PER_TICK);
	localparam logic [CNT_W-1:0] RELOAD = CNT_W'(CLKS_PER_TICK - 1);

	logic [CNT_W-1:0] cnt;  // counts down to zero, then reloads

	if (CLKS_PER_TICK < 2) begin : g_bad_div
		$error("baud_tick_gen: CLKS_PER_TICK must be at least 2");
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			cnt <= '0;
			o_tick <= 1'b0;
		end else if (cnt == '0) begin
			cnt <= RELOAD;  // period is RELOAD+1 clocks
			o_tick <= 1'b1;
		end else begin
			cnt <= cnt - 1'b1;
			o_tick <= 1'b0;
		end
	end

	// the tx and rx bit counters assume a tick is a single-clock strobe
	a_tick_single: assert property (@(posedge clk) disable iff (reset)
		o_tick |=> !o_tick)
		else $error("baud_tick_gen: tick high on two consecutive clocks");

endmodule

`default_nettype wire

// ==== hw/uart_loopback_top.sv ====
`default_nettype none

module uart_loopback_top #(
	parameter int CLKS_PER_TICK = 4,  // clocks per oversampling tick, at least 2
	parameter uart_pkg::parity_mode_e PARITY = uart_pkg::PARITY_EVEN
) (
	input  logic clk,
	input  logic reset,
	input  logic i_tx_start,   // one-clock request, ignored while busy
	input  logic i_loopback,   // high: rx listens to our own tx line
	input  logic i_serial,     // external rx line
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_tx_data,
	output logic o_serial,
	output logic o_tx_busy,
	output logic o_rx_valid,
	output uart_pkg::rx_result_t o_rx_result
);

	logic tick;     // shared oversampling strobe
	logic rx_line;  // line actually seen by the receiver

	assign rx_line = i_loopback ? o_serial : i_serial;  // run-time loopback select

	baud_tick_gen #(
		.CLKS_PER_TICK(CLKS_PER_TICK)
	) u_tick (
		.clk   (clk),
		.reset (reset),
		.o_tick(tick)
	);

	uart_tx #(
		.PARITY(PARITY)
	) u_tx (
		.clk       (clk),
		.reset     (reset),
		.i_tick    (tick),
		.i_tx_start(i_tx_start),
		.i_tx_data (i_tx_data),
		.o_serial  (o_serial),
		.o_tx_busy (o_tx_busy)
	);

	uart_rx #(
		.PARITY(PARITY)
	) u_rx (
		.clk        (clk),
		.reset      (reset),
		.i_tick     (tick),
		.i_rx_line  (rx_line),
		.o_rx_valid (o_rx_valid),
		.o_rx_result(o_rx_result)
	);

endmodule

`default_nettype wire

// ==== hw/uart_pkg.sv ====
`default_nettype none

package uart_pkg;

	localparam int DATA_WIDTH = 8;   // data bits per frame
	localparam int OVERSAMPLE = 8;   // ticks per serial bit
	localparam int SYNC_STAGES = 3;  // flops on the raw rx line

	// frame on the wire, LSB first:
	// start(0) d0 d1 d2 d3 d4 d5 d6 d7 parity stop(1)

	typedef enum logic {
		PARITY_EVEN = 1'b0,  // parity bit makes the count of ones even
		PARITY_ODD  = 1'b1   // parity bit makes the count of ones odd
	} parity_mode_e;

	typedef enum logic [2:0] {
		TX_IDLE   = 3'd0,  // line high, may hold a latched byte waiting for a tick
		TX_START  = 3'd1,  // driving the start bit low
		TX_DATA   = 3'd2,  // shifting data out LSB first
		TX_PARITY = 3'd3,  // driving the parity bit
		TX_STOP   = 3'd4   // driving the stop bit high
	} tx_state_e;

	typedef enum logic [2:0] {
		RX_IDLE   = 3'd0,  // waiting for a falling edge
		RX_START  = 3'd1,  // counting to the middle of the start bit
		RX_DATA   = 3'd2,  // sampling data bits at their centre
		RX_PARITY = 3'd3,  // sampling the parity bit
		RX_STOP   = 3'd4   // sampling the stop bit, then report
	} rx_state_e;

	// what the receiver reports with each valid pulse
	typedef struct packed {
		logic [DATA_WIDTH-1:0] data;  // received byte
		logic parity_error;           // parity bit disagrees with the data
		logic stop_error;             // stop bit sampled low
	} rx_result_t;

endpackage

`default_nettype wire

// ==== hw/uart_rx.sv ====
`default_nettype none

module uart_rx #(
	parameter uart_pkg::parity_mode_e PARITY = uart_pkg::PARITY_EVEN
) (
	input  logic clk,
	input  logic reset,
	input  logic i_tick,
	input  logic i_rx_line,
	output logic o_rx_valid,
	output uart_pkg::rx_result_t o_rx_result
);
	import uart_pkg::*;

	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam int IDX_W = $clog2(DATA_WIDTH);
	localparam logic [TICK_W-1:0] HALF_TICK = TICK_W'(OVERSAMPLE / 2 - 1);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_WIDTH - 1);

	logic [SYNC_STAGES-1:0] sync_ff;  // raw line enters at bit 0
	logic line_s;                     // synchronized line
	logic line_prev;                  // line_s one clock earlier
	logic fall;                       // falling edge on the synchronized line

	rx_state_e state;
	logic [TICK_W-1:0] tick_cnt;      // ticks since the last sample point
	logic [TICK_W-1:0] sample_at;     // tick count of the next sample
	logic [IDX_W-1:0] bit_idx;        // data bit being sampled
	logic sample;                     // sample strobe at the bit centre
	logic [DATA_WIDTH-1:0] shift_reg; // data collected LSB first
	logic parity_rx;                  // parity bit as received
	logic parity_exp;                 // parity bit the data calls for

	assign line_s = sync_ff[SYNC_STAGES-1];
	assign fall = line_prev && !line_s;
	assign sample_at = (state == RX_START) ? HALF_TICK : LAST_TICK;  // half a bit for start
	assign sample = i_tick && (state != RX_IDLE) && (tick_cnt == sample_at);
	assign parity_exp = (^shift_reg) ^ (PARITY == PARITY_ODD);

	always_ff @(posedge clk) begin
		if (reset) begin
			sync_ff <= '1;  // idle high, so no false edge out of reset
			line_prev <= 1'b1;
		end else begin
			sync_ff <= {sync_ff[SYNC_STAGES-2:0], i_rx_line};
			line_prev <= line_s;
		end
	end

	always_ff @(posedge clk) begin
		if (sample && state == RX_DATA)
			shift_reg <= {line_s, shift_reg[DATA_WIDTH-1:1]};  // LSB arrives first
		if (sample && state == RX_PARITY)
			parity_rx <= line_s;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= RX_IDLE;
			tick_cnt <= '0;
			bit_idx <= '0;
			o_rx_valid <= 1'b0;
			o_rx_result <= '0;
		end else begin
			o_rx_valid <= 1'b0;  // single clock pulse
			if (state == RX_IDLE) begin
				if (fall) begin  // edge, not level, so a low stop bit is not a start
					state <= RX_START;
					tick_cnt <= '0;
				end
			end else if (sample) begin
				tick_cnt <= '0;  // next sample one full bit later
				case (state)
					RX_START: begin
						bit_idx <= '0;
						state <= line_s ? RX_IDLE : RX_DATA;  // high again means a glitch
					end
					RX_DATA: begin
						if (bit_idx == LAST_IDX)
							state <= RX_PARITY;
						else
							bit_idx <= bit_idx + 1'b1;
					end
					RX_PARITY: state <= RX_STOP;
					RX_STOP: begin
						state <= RX_IDLE;
						o_rx_valid <= 1'b1;  // reported even with errors
						o_rx_result.data <= shift_reg;
						o_rx_result.parity_error <= (parity_rx != parity_exp);
						o_rx_result.stop_error <= !line_s;
					end
					default: state <= RX_IDLE;
				endcase
			end else if (i_tick) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// consumers count frames by valid pulses, a stretched pulse would count twice
	a_valid_one_clk: assert property (@(posedge clk) disable iff (reset)
		o_rx_valid |=> !o_rx_valid)
		else $error("uart_rx: valid held longer than one clock");

endmodule

`default_nettype wire

// ==== hw/uart_tx.sv ====
`default_nettype none

module uart_tx #(
	parameter uart_pkg::parity_mode_e PARITY = uart_pkg::PARITY_EVEN
) (
	input  logic clk,
	input  logic reset,
	input  logic i_tick,
	input  logic i_tx_start,
	input  logic [uart_pkg::DATA_WIDTH-1:0] i_tx_data,
	output logic o_serial,
	output logic o_tx_busy
);
	import uart_pkg::*;

	localparam int TICK_W = $clog2(OVERSAMPLE);
	localparam int IDX_W = $clog2(DATA_WIDTH);
	localparam logic [TICK_W-1:0] LAST_TICK = TICK_W'(OVERSAMPLE - 1);
	localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(DATA_WIDTH - 1);

	tx_state_e state;
	logic [TICK_W-1:0] tick_cnt;     // ticks spent in the current bit
	logic [IDX_W-1:0] bit_idx;       // which data bit is on the line
	logic [DATA_WIDTH-1:0] shift_reg;  // byte being shifted out, bit 0 next
	logic parity_bit;                // computed once when the byte is latched
	logic accept;                    // start pulse taken this clock
	logic bit_done;                  // last tick of the current bit

	assign accept = i_tx_start && !o_tx_busy;  // pulses while busy are dropped
	assign bit_done = i_tick && (state != TX_IDLE) && (tick_cnt == LAST_TICK);

	always_ff @(posedge clk) begin
		if (accept) begin
			shift_reg <= i_tx_data;
			parity_bit <= (^i_tx_data) ^ (PARITY == PARITY_ODD);  // odd inverts the xor
		end else if (bit_done && (state == TX_START || state == TX_DATA)) begin
			shift_reg <= shift_reg >> 1;  // bit 0 has just gone onto the line
		end
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= TX_IDLE;
			tick_cnt <= '0;
			bit_idx <= '0;
			o_serial <= 1'b1;  // idle line is high
			o_tx_busy <= 1'b0;
		end else begin
			if (accept)
				o_tx_busy <= 1'b1;  // byte latched on this same edge
			if (state == TX_IDLE) begin
				if (i_tick && o_tx_busy) begin  // first tick after the latch
					state <= TX_START;
					o_serial <= 1'b0;
					tick_cnt <= '0;
				end
			end else if (bit_done) begin
				tick_cnt <= '0;
				case (state)
					TX_START: begin
						state <= TX_DATA;
						o_serial <= shift_reg[0];
						bit_idx <= '0;
					end
					TX_DATA: begin
						if (bit_idx == LAST_IDX) begin
							state <= TX_PARITY;
							o_serial <= parity_bit;
						end else begin
							o_serial <= shift_reg[0];  // already shifted one place
							bit_idx <= bit_idx + 1'b1;
						end
					end
					TX_PARITY: begin
						state <= TX_STOP;
						o_serial <= 1'b1;
					end
					TX_STOP: begin
						state <= TX_IDLE;  // line stays high
						o_tx_busy <= 1'b0;
					end
					default: state <= TX_IDLE;
				endcase
			end else if (i_tick) begin
				tick_cnt <= tick_cnt + 1'b1;
			end
		end
	end

	// a low line outside a frame would look like a start bit to the far end
	a_low_only_busy: assert property (@(posedge clk) disable iff (reset)
		!o_serial |-> o_tx_busy)
		else $error("uart_tx: line low while not busy");

	a_start_busy: assert property (@(posedge clk) disable iff (reset)
		(i_tx_start && !o_tx_busy) |=> o_tx_busy)
		else $error("uart_tx: accepted start not followed by busy");

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+include
hw/uart_pkg.sv
hw/baud_tick_gen.sv
hw/uart_tx.sv
hw/uart_rx.sv
hw/uart_loopback_top.sv
tests/tb_uart_top.sv

// ==== include/uart_tb_ref.svh ====
`ifndef UART_TB_REF_SVH
`define UART_TB_REF_SVH

// parity bit a correct transmitter puts after the data
function automatic logic expected_parity(
	input logic [uart_pkg::DATA_WIDTH-1:0] data,
	input uart_pkg::parity_mode_e mode
);
	logic p;
	p = ^data;  // even parity is the plain xor
	if (mode == uart_pkg::PARITY_ODD)
		p = ~p;
	return p;
endfunction

// expected line level for bit index 0 (start) through DATA_WIDTH+2 (stop)
function automatic logic frame_bit(
	input logic [uart_pkg::DATA_WIDTH-1:0] data,
	input int index,
	input uart_pkg::parity_mode_e mode = uart_pkg::PARITY_EVEN
);
	logic b;
	if (index == 0)
		b = 1'b0;  // start
	else if (index <= uart_pkg::DATA_WIDTH)
		b = data[index-1];  // data, LSB first
	else if (index == uart_pkg::DATA_WIDTH + 1)
		b = expected_parity(data, mode);
	else
		b = 1'b1;  // stop, and idle beyond it
	return b;
endfunction

`endif

// ==== tests/tb_uart_top.sv ====
`default_nettype none

module tb_uart_top;
	timeunit 1ns;
	timeprecision 100ps;
	import uart_pkg::*;

	localparam int CLKS_PER_TICK = 4;
	localparam parity_mode_e PARITY = PARITY_EVEN;
	localparam int CLK_NS = 20;
	localparam int BIT_CLKS = CLKS_PER_TICK * OVERSAMPLE;  // 32 clocks per serial bit
	localparam int FRAME_BITS = DATA_WIDTH + 3;             // start, data, parity, stop
	localparam int FRAME_CLKS = FRAME_BITS * BIT_CLKS;
	localparam int NUM_FRAMES = 25;  // 20 round trips, format, two bad frames, busy pair
	localparam int WATCHDOG_NS = NUM_FRAMES * FRAME_BITS * 32 * CLK_NS * 3 / 2;

	logic clk = 1'b0;
	logic reset, i_tx_start, i_loopback, i_serial;
	logic [DATA_WIDTH-1:0] i_tx_data;
	logic o_serial, o_tx_busy, o_rx_valid;
	rx_result_t o_rx_result;

	rx_result_t expected_q[$];  // results still owed by the receiver
	int seed = 8007;
	int error_count = 0;
	int test_start_errors = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int rx_count = 0;           // valid pulses seen so far

	`include "uart_tb_ref.svh"

	uart_loopback_top #(.CLKS_PER_TICK(CLKS_PER_TICK), .PARITY(PARITY)) dut (
		.clk(clk), .reset(reset), .i_tx_start(i_tx_start), .i_loopback(i_loopback),
		.i_serial(i_serial), .i_tx_data(i_tx_data), .o_serial(o_serial),
		.o_tx_busy(o_tx_busy), .o_rx_valid(o_rx_valid), .o_rx_result(o_rx_result)
	);

	always #(CLK_NS / 2) clk = ~clk;

	function automatic logic [FRAME_BITS-1:0] build_frame(input logic [DATA_WIDTH-1:0] data);
		logic [FRAME_BITS-1:0] bits;
		for (int i = 0; i < FRAME_BITS; i++)
			bits[i] = frame_bit(data, i, PARITY);  // bit 0 goes on the line first
		return bits;
	endfunction

	// what a receiver must report for the bits it saw on the line
	function automatic rx_result_t decode_frame(input logic [FRAME_BITS-1:0] bits);
		rx_result_t r;
		for (int i = 0; i < DATA_WIDTH; i++)
			r.data[i] = bits[i+1];
		r.parity_error = (bits[DATA_WIDTH+1] != expected_parity(r.data, PARITY));
		r.stop_error = (bits[FRAME_BITS-1] != 1'b1);
		return r;
	endfunction

	task automatic check_value(input string name, input int exp, input int got);
		assert (got == exp) else begin
			error_count++;
			$display("** Error at %0d ns: %s expected 0x%0h, got 0x%0h", $time, name, exp, got);
		end
	endtask

	task automatic send_byte(input logic [DATA_WIDTH-1:0] data, input logic expect_rx);
		@(posedge clk);
		i_tx_data <= data;
		i_tx_start <= 1'b1;
		if (expect_rx)
			expected_q.push_back(decode_frame(build_frame(data)));
		@(posedge clk);
		i_tx_start <= 1'b0;  // one clock pulse
	endtask

	task automatic wait_tx_idle();
		int n;
		n = 0;
		@(negedge clk);
		while (o_tx_busy && n < 2 * FRAME_CLKS) begin
			@(negedge clk);
			n++;
		end
		assert (!o_tx_busy) else begin
			error_count++;
			$display("transmitter stayed busy for %0d clocks at %0d ns", n, $time);
		end
	endtask

	task automatic wait_rx_drained();
		int n;
		n = 0;
		while (expected_q.size() != 0 && n < 2 * FRAME_CLKS) begin
			@(negedge clk);
			n++;
		end
		assert (expected_q.size() == 0) else begin
			error_count++;
			$display("missing valid pulse, %0d frame(s) never received", expected_q.size());
			expected_q.delete();
		end
	endtask

	task automatic drive_frame(input logic [FRAME_BITS-1:0] bits);
		for (int i = 0; i < FRAME_BITS; i++) begin
			@(posedge clk);
			i_serial <= bits[i];
			repeat (BIT_CLKS - 1) @(posedge clk);
		end
		@(posedge clk);
		i_serial <= 1'b1;  // back to idle
	endtask

	task automatic report_test(input string name);
		if (error_count == test_start_errors) begin
			tests_passed++;
			$display("test %-26s passed at %0d ns", name, $time);
		end else begin
			tests_failed++;
			$display("test %-26s failed with %0d error(s)", name, error_count - test_start_errors);
		end
		test_start_errors = error_count;
	endtask

	// compare every receiver result against the oldest outstanding frame
	always @(negedge clk) begin
		rx_result_t exp_r;
		if (!reset && o_rx_valid) begin
			rx_count++;
			assert (expected_q.size() > 0) else begin
				error_count++;
				$display("unexpected valid pulse at %0d ns with no frame outstanding", $time);
			end
			if (expected_q.size() > 0) begin
				exp_r = expected_q.pop_front();
				check_value("o_rx_result.data", int'(exp_r.data), int'(o_rx_result.data));
				check_value("o_rx_result.parity_error", int'(exp_r.parity_error),
					int'(o_rx_result.parity_error));
				check_value("o_rx_result.stop_error", int'(exp_r.stop_error),
					int'(o_rx_result.stop_error));
			end
		end
	end

	initial begin
		#(WATCHDOG_NS);
		$display("watchdog expired at %0d ns, the run did not finish in time", $time);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		int r;
		int rx_before;
		logic [DATA_WIDTH-1:0] data_a;
		logic [FRAME_BITS-1:0] bits;
		reset = 1'b1;
		i_tx_start = 1'b0;
		i_loopback = 1'b1;
		i_serial = 1'b1;  // idle line
		i_tx_data = '0;
		repeat (5) @(posedge clk);
		reset <= 1'b0;
		@(negedge clk);
		check_value("o_serial", 1, int'(o_serial));
		check_value("o_tx_busy", 0, int'(o_tx_busy));
		check_value("o_rx_valid", 0, int'(o_rx_valid));
		report_test("reset values");

		for (int i = 0; i < 20; i++) begin
			wait_tx_idle();
			r = $random(seed);
			send_byte(r[DATA_WIDTH-1:0], 1'b1);
		end
		wait_rx_drained();
		wait_tx_idle();
		report_test("loopback round trip");

		r = $random(seed);
		data_a = r[DATA_WIDTH-1:0];
		send_byte(data_a, 1'b1);
		@(negedge o_serial);                   // start bit begins
		repeat (BIT_CLKS / 2) @(negedge clk);  // centre of the start bit
		for (int i = 0; i < FRAME_BITS; i++) begin
			if (i > 0)
				repeat (BIT_CLKS) @(negedge clk);
			check_value($sformatf("o_serial bit %0d", i), int'(frame_bit(data_a, i, PARITY)),
				int'(o_serial));
		end
		wait_rx_drained();
		wait_tx_idle();
		report_test("transmit frame format");

		@(posedge clk);
		i_loopback <= 1'b0;  // listen to i_serial
		r = $random(seed);
		bits = build_frame(r[DATA_WIDTH-1:0]);
		bits[DATA_WIDTH+1] = ~bits[DATA_WIDTH+1];  // wrong parity
		expected_q.push_back(decode_frame(bits));
		drive_frame(bits);
		wait_rx_drained();
		report_test("receive bad parity");

		r = $random(seed);
		bits = build_frame(r[DATA_WIDTH-1:0]);
		bits[FRAME_BITS-1] = 1'b0;  // stop bit low
		expected_q.push_back(decode_frame(bits));
		drive_frame(bits);
		repeat (FRAME_CLKS) @(posedge clk);  // a false start would finish a frame by now
		wait_rx_drained();
		report_test("receive bad stop bit");

		@(posedge clk);
		i_loopback <= 1'b1;
		r = $random(seed);
		data_a = r[DATA_WIDTH-1:0];
		send_byte(data_a, 1'b1);
		rx_before = rx_count;
		repeat (3 * BIT_CLKS) @(posedge clk);  // well inside the frame
		send_byte(~data_a, 1'b0);              // must be dropped
		wait_tx_idle();
		assert (rx_count - rx_before == 1) else begin
			error_count++;
			$display("expected one valid pulse before busy fell, saw %0d", rx_count - rx_before);
		end
		wait_rx_drained();
		repeat (2 * BIT_CLKS) @(negedge clk);
		check_value("o_tx_busy", 0, int'(o_tx_busy));
		report_test("start ignored while busy");

		$display("summary: %0d tests passed, %0d tests failed, %0d errors", tests_passed,
			tests_failed, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

`default_nettype wire
